// ==== bus_pkg.sv ====
package bus_pkg;

    // --------------------
    // Bus geometry
    // --------------------

    // Data and address width
    localparam int XLEN = 32;

    // Requesting core ports and index width
    localparam int NUM_CORES = 4;
    localparam int CORE_ID_W = 2;

    // One enable per byte lane
    localparam int BE_W = XLEN / 8;

    // --------------------
    // Device request
    // --------------------

    // 70 bits, req sits in the top bit
    typedef struct packed {
        logic            req;
        logic            we;
        logic [XLEN-1:0] addr;
        logic [BE_W-1:0] be;
        logic [XLEN-1:0] wdata;
    } dev_req_t;

endpackage

// ==== dev_map_pkg.sv ====
package dev_map_pkg;

    // --------------------
    // Address map
    // --------------------

    // Address bits 31:30 for the device region
    localparam logic [1:0] DEV_REGION = 2'b11;

    // Device field, address bits 27:24
    localparam logic [3:0] DEV_UART = 4'h0;
    localparam logic [3:0] DEV_INTC = 4'h4;

    // --------------------
    // Register offsets
    // --------------------

    localparam int REG_OFS_W = 4;

    localparam logic [REG_OFS_W-1:0] UART_TXDATA_OFS  = 4'h0;
    localparam logic [REG_OFS_W-1:0] INTC_PENDING_OFS = 4'h0;  // read only
    localparam logic [REG_OFS_W-1:0] INTC_ENABLE_OFS  = 4'h4;
    localparam logic [REG_OFS_W-1:0] INTC_CLEAR_OFS   = 4'h8;  // write 1 to clear

    // Interrupt sources
    localparam int NUM_IRQ_SRC  = 2;
    localparam int IRQ_SRC_UART = 0;
    localparam int IRQ_SRC_EXT  = 1;

endpackage

// ==== device_arbiter.sv ====
`timescale 1ns/1ps

module device_arbiter (
    input  logic                          clk,
    input  logic                          rst_i,
    input  bus_pkg::dev_req_t             core_req_i [bus_pkg::NUM_CORES],
    output logic [bus_pkg::NUM_CORES-1:0] core_ack_o,
    output logic [bus_pkg::XLEN-1:0]      core_rdata_o [bus_pkg::NUM_CORES],
    output bus_pkg::dev_req_t             dev_req_o,
    input  logic                          dev_ack_i,
    input  logic [bus_pkg::XLEN-1:0]      dev_rdata_i
);

    typedef logic [bus_pkg::CORE_ID_W-1:0] core_id_t;

    core_id_t          rr_q;
    core_id_t          grant_q;
    logic              busy_q;
    logic              fwd_req_q;
    bus_pkg::dev_req_t fwd_q;
    core_id_t          pick_idx;
    logic              pick_valid;
    core_id_t          sel_idx;
    logic              done;

    // Round-robin pick, rr_q has top priority
    always_comb begin
        pick_valid = 1'b0;
        pick_idx   = rr_q;
        for (int k = bus_pkg::NUM_CORES - 1; k >= 0; k--) begin
            if (core_req_i[rr_q + core_id_t'(k)].req) begin
                pick_valid = 1'b1;
                pick_idx   = rr_q + core_id_t'(k);
            end
        end
    end

    assign sel_idx = busy_q ? grant_q : pick_idx;

    // Forwarded req has dropped and the target has released ack
    assign done = busy_q && !fwd_req_q && !dev_ack_i;

    // --------------------
    // Grant state
    // --------------------
    always_ff @(posedge clk) begin
        if (rst_i) begin
            busy_q    <= 1'b0;
            grant_q   <= '0;
            rr_q      <= '0;
            fwd_req_q <= 1'b0;
        end else begin
            if (!busy_q) begin
                if (pick_valid) begin
                    busy_q  <= 1'b1;
                    grant_q <= pick_idx;
                end
            end else if (done) begin
                busy_q <= 1'b0;
                rr_q   <= grant_q + 1'b1;
            end
            fwd_req_q <= busy_q ? core_req_i[grant_q].req : pick_valid;
        end
    end

    // Payload follows the selected core every cycle
    always_ff @(posedge clk) begin
        fwd_q <= core_req_i[sel_idx];
    end

    always_comb begin
        dev_req_o     = fwd_q;
        dev_req_o.req = fwd_req_q;
    end

    // --------------------
    // Response steering
    // --------------------
    always_comb begin
        for (int i = 0; i < bus_pkg::NUM_CORES; i++) begin
            core_ack_o[i]   = busy_q && (grant_q == core_id_t'(i)) && dev_ack_i;
            core_rdata_o[i] = (busy_q && (grant_q == core_id_t'(i))) ? dev_rdata_i : '0;
        end
    end

endmodule

// ==== device_decoder.sv ====
`timescale 1ns/1ps

module device_decoder (
    input  logic                                clk,
    input  logic                                rst_i,
    input  bus_pkg::dev_req_t                   req_i,
    input  logic                                uart_ack_i,
    input  logic [bus_pkg::XLEN-1:0]            uart_rdata_i,
    input  logic                                intc_ack_i,
    input  logic [bus_pkg::XLEN-1:0]            intc_rdata_i,
    output logic                                ack_o,
    output logic [bus_pkg::XLEN-1:0]            rdata_o,
    output logic                                uart_req_o,
    output logic                                intc_req_o,
    output logic [dev_map_pkg::REG_OFS_W-1:0]   reg_ofs_o,
    output logic                                we_o,
    output logic [bus_pkg::BE_W-1:0]            be_o,
    output logic [bus_pkg::XLEN-1:0]            wdata_o
);

    logic in_region;
    logic hit_uart;
    logic hit_intc;
    logic dflt_ack_q;

    assign in_region = (req_i.addr[31:30] == dev_map_pkg::DEV_REGION);
    assign hit_uart  = in_region && (req_i.addr[27:24] == dev_map_pkg::DEV_UART);
    assign hit_intc  = in_region && (req_i.addr[27:24] == dev_map_pkg::DEV_INTC);

    assign uart_req_o = req_i.req && hit_uart;
    assign intc_req_o = req_i.req && hit_intc;

    // Shared write and offset lines
    assign reg_ofs_o = req_i.addr[dev_map_pkg::REG_OFS_W-1:0];
    assign we_o      = req_i.we;
    assign be_o      = req_i.be;
    assign wdata_o   = req_i.wdata;

    // Default responder, so an unmapped access never stalls a core
    always_ff @(posedge clk) begin
        if (rst_i) begin
            dflt_ack_q <= 1'b0;
        end else begin
            dflt_ack_q <= req_i.req && !hit_uart && !hit_intc;
        end
    end

    assign ack_o = uart_ack_i | intc_ack_i | dflt_ack_q;

    // Zero data unless a real target answers
    always_comb begin
        rdata_o = '0;
        if (uart_ack_i) begin
            rdata_o = uart_rdata_i;
        end else if (intc_ack_i) begin
            rdata_o = intc_rdata_i;
        end
    end

endmodule

// ==== uart_tx_stub.sv ====
`timescale 1ns/1ps

module uart_tx_stub (
    input  logic                              clk,
    input  logic                              rst_i,
    input  logic                              req_i,
    input  logic                              we_i,
    input  logic [bus_pkg::BE_W-1:0]          be_i,
    input  logic [bus_pkg::XLEN-1:0]          wdata_i,
    input  logic [dev_map_pkg::REG_OFS_W-1:0] reg_ofs_i,
    output logic                              ack_o,
    output logic [bus_pkg::XLEN-1:0]          rdata_o,
    output logic                              tx_valid_o,
    output logic [7:0]                        tx_data_o,
    output logic                              done_o
);

    typedef logic [bus_pkg::XLEN-1:0] word_t;

    logic       ack_q;
    logic       tx_valid_q;
    logic [7:0] txdata_q;
    word_t      rdata_q;
    logic       start;
    logic       tx_hit;

    // First cycle of a request
    assign start  = req_i && !ack_q;
    assign tx_hit = start && we_i && be_i[0] && (reg_ofs_i == dev_map_pkg::UART_TXDATA_OFS);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ack_q      <= 1'b0;
            tx_valid_q <= 1'b0;
        end else begin
            ack_q      <= req_i;
            tx_valid_q <= tx_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (tx_hit) begin
            txdata_q <= wdata_i[7:0];
        end
        if (start) begin
            rdata_q <= (reg_ofs_i == dev_map_pkg::UART_TXDATA_OFS) ? word_t'(txdata_q) : '0;
        end
    end

    assign ack_o      = ack_q;
    assign rdata_o    = rdata_q;
    assign tx_valid_o = tx_valid_q;
    assign tx_data_o  = txdata_q;
    assign done_o     = tx_valid_q;   // doubles as the transmit-done interrupt

endmodule

// ==== intc.sv ====
`timescale 1ns/1ps

module intc (
    input  logic                                clk,
    input  logic                                rst_i,
    input  logic                                req_i,
    input  logic                                we_i,
    input  logic [bus_pkg::BE_W-1:0]            be_i,
    input  logic [bus_pkg::XLEN-1:0]            wdata_i,
    input  logic [dev_map_pkg::REG_OFS_W-1:0]   reg_ofs_i,
    input  logic [dev_map_pkg::NUM_IRQ_SRC-1:0] src_i,
    output logic                                ack_o,
    output logic [bus_pkg::XLEN-1:0]            rdata_o,
    output logic                                irq_o
);

    typedef logic [bus_pkg::XLEN-1:0] word_t;
    typedef logic [dev_map_pkg::NUM_IRQ_SRC-1:0] src_t;

    logic  ack_q;
    src_t  pending_q;
    src_t  enable_q;
    src_t  clr;
    word_t rdata_q;
    logic  start;
    logic  wr;

    assign start = req_i && !ack_q;
    assign wr    = start && we_i && be_i[0];

    // Write-1-to-clear mask for this cycle
    assign clr = (wr && (reg_ofs_i == dev_map_pkg::INTC_CLEAR_OFS))
                 ? wdata_i[dev_map_pkg::NUM_IRQ_SRC-1:0] : '0;

    // --------------------
    // Control registers
    // --------------------
    always_ff @(posedge clk) begin
        if (rst_i) begin
            ack_q     <= 1'b0;
            pending_q <= '0;
            enable_q  <= '0;
        end else begin
            ack_q <= req_i;
            // New pulse beats a clear on the same bit
            pending_q <= (pending_q & ~clr) | src_i;
            if (wr && (reg_ofs_i == dev_map_pkg::INTC_ENABLE_OFS)) begin
                enable_q <= wdata_i[dev_map_pkg::NUM_IRQ_SRC-1:0];
            end
        end
    end

    // Read data captured with the ack
    always_ff @(posedge clk) begin
        if (start) begin
            case (reg_ofs_i)
                dev_map_pkg::INTC_PENDING_OFS: rdata_q <= word_t'(pending_q);
                dev_map_pkg::INTC_ENABLE_OFS:  rdata_q <= word_t'(enable_q);
                default:                       rdata_q <= '0;
            endcase
        end
    end

    assign ack_o   = ack_q;
    assign rdata_o = rdata_q;
    assign irq_o   = |(pending_q & enable_q);

endmodule

// ==== device_subsystem.sv ====
`timescale 1ns/1ps

module device_subsystem (
    input  logic                          clk,
    input  logic                          rst_i,
    input  bus_pkg::dev_req_t             dev_req_i [bus_pkg::NUM_CORES],
    output logic [bus_pkg::NUM_CORES-1:0] dev_ack_o,
    output logic [bus_pkg::XLEN-1:0]      dev_rdata_o [bus_pkg::NUM_CORES],
    input  logic                          ext_irq_i,
    output logic                          uart_tx_valid_o,
    output logic [7:0]                    uart_tx_data_o,
    output logic                          irq_o
);

    bus_pkg::dev_req_t                   arb_req;
    logic                                dec_ack;
    logic [bus_pkg::XLEN-1:0]            dec_rdata;
    logic                                uart_req;
    logic                                uart_ack;
    logic [bus_pkg::XLEN-1:0]            uart_rdata;
    logic                                uart_done;
    logic                                intc_req;
    logic                                intc_ack;
    logic [bus_pkg::XLEN-1:0]            intc_rdata;
    logic [dev_map_pkg::REG_OFS_W-1:0]   reg_ofs;
    logic                                we;
    logic [bus_pkg::BE_W-1:0]            be;
    logic [bus_pkg::XLEN-1:0]            wdata;
    logic [dev_map_pkg::NUM_IRQ_SRC-1:0] irq_src;

    // Interrupt source bus
    assign irq_src[dev_map_pkg::IRQ_SRC_UART] = uart_done;
    assign irq_src[dev_map_pkg::IRQ_SRC_EXT]  = ext_irq_i;

    device_arbiter u_arbiter (
        .clk          (clk),
        .rst_i        (rst_i),
        .core_req_i   (dev_req_i),
        .core_ack_o   (dev_ack_o),
        .core_rdata_o (dev_rdata_o),
        .dev_req_o    (arb_req),
        .dev_ack_i    (dec_ack),
        .dev_rdata_i  (dec_rdata)
    );

    device_decoder u_decoder (
        .clk          (clk),
        .rst_i        (rst_i),
        .req_i        (arb_req),
        .uart_ack_i   (uart_ack),
        .uart_rdata_i (uart_rdata),
        .intc_ack_i   (intc_ack),
        .intc_rdata_i (intc_rdata),
        .ack_o        (dec_ack),
        .rdata_o      (dec_rdata),
        .uart_req_o   (uart_req),
        .intc_req_o   (intc_req),
        .reg_ofs_o    (reg_ofs),
        .we_o         (we),
        .be_o         (be),
        .wdata_o      (wdata)
    );

    uart_tx_stub u_uart (
        .clk        (clk),
        .rst_i      (rst_i),
        .req_i      (uart_req),
        .we_i       (we),
        .be_i       (be),
        .wdata_i    (wdata),
        .reg_ofs_i  (reg_ofs),
        .ack_o      (uart_ack),
        .rdata_o    (uart_rdata),
        .tx_valid_o (uart_tx_valid_o),
        .tx_data_o  (uart_tx_data_o),
        .done_o     (uart_done)
    );

    intc u_intc (
        .clk       (clk),
        .rst_i     (rst_i),
        .req_i     (intc_req),
        .we_i      (we),
        .be_i      (be),
        .wdata_i   (wdata),
        .reg_ofs_i (reg_ofs),
        .src_i     (irq_src),
        .ack_o     (intc_ack),
        .rdata_o   (intc_rdata),
        .irq_o     (irq_o)
    );

endmodule

// ==== tb_device_subsystem_assert.sv ====
`timescale 1ns/1ps

module tb_device_subsystem_assert (
    input logic                                clk,
    input logic                                rst_i,
    input bus_pkg::dev_req_t                   dev_req_i [bus_pkg::NUM_CORES],
    input logic [bus_pkg::NUM_CORES-1:0]       dev_ack_o,
    input logic                                uart_tx_valid_o,
    input logic                                irq_o,
    input logic                                ext_irq_i,
    input logic                                arb_busy,
    input logic [dev_map_pkg::NUM_IRQ_SRC-1:0] irq_enable
);

    typedef logic [bus_pkg::NUM_CORES-1:0] core_vec_t;

    core_vec_t req_vec;
    core_vec_t ack_d;
    core_vec_t ack_rise;
    core_vec_t unfair;
    core_vec_t served_q [bus_pkg::NUM_CORES];

    always_comb begin
        for (int i = 0; i < bus_pkg::NUM_CORES; i++) begin
            req_vec[i] = dev_req_i[i].req;
        end
    end

    assign ack_rise = dev_ack_o & ~ack_d;

    // --------------------
    // Fairness tracking
    // --------------------

    // served_q[j] marks cores acknowledged while core j was waiting
    always_ff @(posedge clk) begin
        if (rst_i) begin
            ack_d <= '0;
            for (int j = 0; j < bus_pkg::NUM_CORES; j++) begin
                served_q[j] <= '0;
            end
        end else begin
            ack_d <= dev_ack_o;
            for (int j = 0; j < bus_pkg::NUM_CORES; j++) begin
                if (!req_vec[j] || dev_ack_o[j]) begin
                    served_q[j] <= '0;
                end else begin
                    served_q[j] <= served_q[j] | ack_rise;
                end
            end
        end
    end

    always_comb begin
        for (int j = 0; j < bus_pkg::NUM_CORES; j++) begin
            unfair[j] = req_vec[j] && !dev_ack_o[j] && |(served_q[j] & ack_rise);
        end
    end

    a_reset: assert property (@(posedge clk)
        $fell(rst_i) |-> (dev_ack_o == '0) && !uart_tx_valid_o && !irq_o)
        else $error("outputs not low after reset");

    a_one_ack: assert property (@(posedge clk) disable iff (rst_i) $onehot0(dev_ack_o))
        else $error("more than one core acknowledged");

    a_fair: assert property (@(posedge clk) disable iff (rst_i) !(|unfair))
        else $error("core acknowledged twice while another waited");

    a_tx_pulse: assert property (@(posedge clk) disable iff (rst_i)
        uart_tx_valid_o |=> !uart_tx_valid_o)
        else $error("transmit valid longer than one cycle");

    a_irq_uart: assert property (@(posedge clk) disable iff (rst_i)
        uart_tx_valid_o && irq_enable[0] |=> irq_o)
        else $error("enabled UART interrupt did not raise irq");

    a_ext_masked: assert property (@(posedge clk) disable iff (rst_i)
        ext_irq_i && !irq_enable[1] && !irq_o && !uart_tx_valid_o |=> !irq_o)
        else $error("masked external interrupt raised irq");

    for (genvar i = 0; i < bus_pkg::NUM_CORES; i++) begin : g_core
        a_ack_rise: assert property (@(posedge clk) disable iff (rst_i)
            $rose(dev_ack_o[i]) |-> req_vec[i])
            else $error("ack rose without req on core %0d", i);

        a_ack_fall: assert property (@(posedge clk) disable iff (rst_i)
            $fell(dev_ack_o[i]) |-> !req_vec[i])
            else $error("ack fell while req high on core %0d", i);

        // Idle bus latency of two cycles
        a_latency: assert property (@(posedge clk) disable iff (rst_i)
            $rose(req_vec[i]) && !arb_busy && ((req_vec & ~(core_vec_t'(1) << i)) == '0)
            |-> ##2 $rose(dev_ack_o[i]))
            else $error("idle bus ack latency wrong on core %0d", i);
    end

endmodule

bind device_subsystem tb_device_subsystem_assert u_assert (
    .clk             (clk),
    .rst_i           (rst_i),
    .dev_req_i       (dev_req_i),
    .dev_ack_o       (dev_ack_o),
    .uart_tx_valid_o (uart_tx_valid_o),
    .irq_o           (irq_o),
    .ext_irq_i       (ext_irq_i),
    .arb_busy        (u_arbiter.busy_q),
    .irq_enable      (u_intc.enable_q)
);

// ==== tb_device_subsystem.sv ====
`timescale 1ns/1ps

module tb_device_subsystem;

    logic                          clk;
    logic                          rst_i;
    bus_pkg::dev_req_t             dev_req [bus_pkg::NUM_CORES];
    logic [bus_pkg::NUM_CORES-1:0] dev_ack;
    logic [bus_pkg::XLEN-1:0]      dev_rdata [bus_pkg::NUM_CORES];
    logic                          ext_irq;
    logic                          uart_tx_valid;
    logic [7:0]                    uart_tx_data;
    logic                          irq;
    logic [15:0]                   lfsr_q;
    logic [7:0]                    last_tx;
    int                            tx_count;
    int                            cycle_count;

    device_subsystem u_dut (
        .clk             (clk),
        .rst_i           (rst_i),
        .dev_req_i       (dev_req),
        .dev_ack_o       (dev_ack),
        .dev_rdata_o     (dev_rdata),
        .ext_irq_i       (ext_irq),
        .uart_tx_valid_o (uart_tx_valid),
        .uart_tx_data_o  (uart_tx_data),
        .irq_o           (irq)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Fibonacci LFSR, taps 16 14 13 11
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
        lfsr_q = {lfsr_q[14:0], fb};
        return fb;
    endfunction

    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[6:0], lfsr_bit()};
        end
        return v;
    endfunction

    function automatic logic [31:0] dev_addr(input logic [3:0] dev, input logic [3:0] ofs);
        return {dev_map_pkg::DEV_REGION, 2'b00, dev, 20'h0, ofs};
    endfunction

    // --------------------
    // Bus tasks
    // --------------------

    // One full four-phase transaction, entered and left on a rising edge
    task automatic transact(input int core, input logic we, input logic [31:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
        dev_req[core] <= '{req: 1'b1, we: we, addr: addr, be: '1, wdata: wdata};
        do @(posedge clk); while (!dev_ack[core]);
        rdata = dev_rdata[core];
        dev_req[core].req <= 1'b0;
        do @(posedge clk); while (dev_ack[core]);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (act !== exp) begin
            $display("Mismatch in %s: expected 0x%08h, actual 0x%08h", name, exp, act);
            $display("FAIL: see errors above");
            $fatal(1, "%s check failed", name);
        end
    endtask

    task automatic write_reg(input int core, input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        transact(core, 1'b1, addr, data, unused);
    endtask

    task automatic read_check(input string name, input int core, input logic [31:0] addr,
                              input logic [31:0] exp);
        logic [31:0] got;
        transact(core, 1'b0, addr, 32'h0, got);
        check_value(name, exp, got);
    endtask

    // Random set of cores, each reading the unmapped field twice in a row
    task automatic contention_round();
        logic [7:0] mask;
        mask = rand_bits(bus_pkg::NUM_CORES);
        if (mask == 8'h0) begin
            mask = 8'h0f;
        end
        for (int c = 0; c < bus_pkg::NUM_CORES; c++) begin
            if (mask[c]) begin
                fork
                    automatic int cc = c;
                    begin
                        repeat (2) begin
                            read_check("unmapped_read", cc, dev_addr(4'h8, 4'h0), 32'h0);
                        end
                    end
                join_none
            end
        end
        wait fork;
    endtask

    // Cycle counter, transmit monitor and timeout
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (uart_tx_valid) begin
            last_tx  <= uart_tx_data;
            tx_count <= tx_count + 1;
        end
        if (cycle_count >= 2000) begin
            $display("Timeout: the run did not finish within 2000 cycles");
            $display("FAIL: see errors above");
            $fatal(1, "timeout");
        end
    end

    initial begin
        logic [7:0] byte_v;
        int         tx_before;
        lfsr_q  = 16'd33285;
        rst_i   <= 1'b1;
        ext_irq <= 1'b0;
        for (int c = 0; c < bus_pkg::NUM_CORES; c++) begin
            dev_req[c] <= '0;
        end
        repeat (3) @(posedge clk);
        rst_i <= 1'b0;
        @(posedge clk);

        // UART write and read-back from each core on an idle bus
        repeat (2) begin
            for (int c = 0; c < bus_pkg::NUM_CORES; c++) begin
                byte_v    = rand_bits(8);
                tx_before = tx_count;
                write_reg(c, dev_addr(dev_map_pkg::DEV_UART, 4'h0), {24'h0, byte_v});
                check_value("uart_tx_count", tx_before + 1, tx_count);
                check_value("uart_tx_byte", {24'h0, byte_v}, {24'h0, last_tx});
                read_check("uart_readback", c, dev_addr(dev_map_pkg::DEV_UART, 4'h0),
                           {24'h0, byte_v});
            end
        end

        repeat (10) contention_round();

        // --------------------
        // Interrupts
        // --------------------

        // UART source is pending but still masked
        check_value("irq_idle", 32'h0, {31'h0, irq});
        write_reg(0, dev_addr(dev_map_pkg::DEV_INTC, dev_map_pkg::INTC_CLEAR_OFS), 32'h3);
        write_reg(1, dev_addr(dev_map_pkg::DEV_INTC, dev_map_pkg::INTC_ENABLE_OFS), 32'h1);
        byte_v = rand_bits(8);
        write_reg(2, dev_addr(dev_map_pkg::DEV_UART, 4'h0), {24'h0, byte_v});
        check_value("irq_after_uart", 32'h1, {31'h0, irq});
        read_check("intc_pending", 3,
                   dev_addr(dev_map_pkg::DEV_INTC, dev_map_pkg::INTC_PENDING_OFS), 32'h1);
        write_reg(0, dev_addr(dev_map_pkg::DEV_INTC, dev_map_pkg::INTC_CLEAR_OFS), 32'h1);
        check_value("irq_after_clear", 32'h0, {31'h0, irq});

        // External pulse while source 1 stays masked
        ext_irq <= 1'b1;
        @(posedge clk);
        ext_irq <= 1'b0;
        repeat (2) @(posedge clk);
        check_value("irq_ext_masked", 32'h0, {31'h0, irq});
        read_check("intc_pending_ext", 1,
                   dev_addr(dev_map_pkg::DEV_INTC, dev_map_pkg::INTC_PENDING_OFS), 32'h2);
        read_check("intc_enable", 2,
                   dev_addr(dev_map_pkg::DEV_INTC, dev_map_pkg::INTC_ENABLE_OFS), 32'h1);

        $display("PASS: all tests");
        $finish;
    end

endmodule

// ==== list.f ====
bus_pkg.sv
dev_map_pkg.sv
device_arbiter.sv
device_decoder.sv
uart_tx_stub.sv
intc.sv
device_subsystem.sv
tb_device_subsystem_assert.sv
tb_device_subsystem.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_device_subsystem \
    -f list.f -o sim_device_subsystem

status=0
./obj_dir/sim_device_subsystem > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "FAIL: see errors above" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"
